// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the attitude path testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module flight_ctrl_tb \
    --Mdir "$BUILD_DIR" \
    -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vflight_ctrl_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== sim/flight_cases.txt ====
# throttle roll pitch yaw x_angle y_angle z_angle x_rate y_rate z_rate imu_good
# then expected motor_1_rate motor_2_rate motor_3_rate motor_4_rate, all decimal
# Centered sticks, level, at rest
100 128 128 128    0    0   0    0   0   0 1  100 100 100 100
# Roll, pitch and yaw deflections with motion
120 160 100 140  -40   64  25   10  20 -30 1  105 119 109 147
# Roll command saturates high, motors 1 and 4 clamp at max
240 255 128 128    0    0   0 -600   0   0 1  250 176 176 250
# Pitch command saturates low, motors 1 and 2 clamp at zero
 30 128   0 128    0    0   0    0 600   0 1    0   0  94  94
# Throttle below idle
 10 200 128 128    0    0   0    0   0   0 1    0   0   0   0
# IMU flagged bad
150 128 128 128    0    0   0    0   0   0 0    0   0   0   0
# Full yaw stick, command right at the limit
128 128 128  64    0    0   0    0   0   0 1  192  64 192  64
# Small deflections against negative angles and rates
 80 100 150 120   32 -100   5   -5  16 -40 1   84  84  88  64
# Throttle exactly at idle arms
 16 128 128 128    0    0   0    0   0   0 1   16  16  16  16

// ==== sim/flight_ctrl_assertions.sv ====
// Bound checks on strobe latency, motor rate range and PWM state in reset for the attitude path top
`timescale 1ns/1ps

module flight_ctrl_assertions (
    input logic                    sys_clk,
    input logic                    resetn,
    input logic                    imu_valid,
    input logic                    motor_valid,
    input flight_pkg::motor_rate_t motor_1_rate,
    input flight_pkg::motor_rate_t motor_2_rate,
    input flight_pkg::motor_rate_t motor_3_rate,
    input flight_pkg::motor_rate_t motor_4_rate,
    input logic                    motor_1_pwm,
    input logic                    motor_2_pwm,
    input logic                    motor_3_pwm,
    input logic                    motor_4_pwm
);

    localparam flight_pkg::motor_rate_t RATE_MAX =
        flight_pkg::motor_rate_t'(flight_pkg::MOTOR_MAX);

    // Angle, rate and mixer stages, one register each
    valid_latency: assert property (
        @(posedge sys_clk) disable iff (!resetn) motor_valid == $past(imu_valid, 3)
    ) else $error("motor_valid does not trail imu_valid by three cycles");

    rate_range: assert property (
        @(posedge sys_clk) (motor_1_rate <= RATE_MAX) && (motor_2_rate <= RATE_MAX) &&
                           (motor_3_rate <= RATE_MAX) && (motor_4_rate <= RATE_MAX)
    ) else $error("motor rate above MOTOR_MAX");

    // ESCs see no pulse while held in reset
    pwm_in_reset: assert property (
        @(posedge sys_clk) !resetn |-> !(motor_1_pwm || motor_2_pwm || motor_3_pwm || motor_4_pwm)
    ) else $error("PWM output high during reset");

endmodule

bind flight_ctrl_top flight_ctrl_assertions u_timing_checks (
    .sys_clk(sys_clk),
    .resetn(resetn),
    .imu_valid(imu_valid),
    .motor_valid(motor_valid),
    .motor_1_rate(motor_1_rate),
    .motor_2_rate(motor_2_rate),
    .motor_3_rate(motor_3_rate),
    .motor_4_rate(motor_4_rate),
    .motor_1_pwm(motor_1_pwm),
    .motor_2_pwm(motor_2_pwm),
    .motor_3_pwm(motor_3_pwm),
    .motor_4_pwm(motor_4_pwm)
);

// ==== sim/flight_ctrl_tb.sv ====
// Attitude path testbench replaying file cases and checking motor rates, latency and ESC pulse widths
`timescale 1ns/1ps

module flight_ctrl_tb;

    // Short PWM timing, one frame is 560 clocks
    localparam int TICK_DIV     = 2;
    localparam int PULSE_MIN    = 8;
    localparam int FRAME_TICKS  = 280;
    localparam int FRAME_CYCLES = FRAME_TICKS * TICK_DIV;
    localparam int CLK_PERIOD   = 100;
    // Three registered stages up to the telemetry rates
    localparam int LATENCY      = 3;
    localparam int VALID_WAIT   = 16;
    localparam int MAX_CASES    = 64;
    // Sticks, angles, rates, imu_good, four expected rates
    localparam int NUM_COLS     = 15;

    logic                    sys_clk;
    logic                    resetn;
    flight_pkg::stick_t      throttle_val;
    flight_pkg::stick_t      roll_val;
    flight_pkg::stick_t      pitch_val;
    flight_pkg::stick_t      yaw_val;
    flight_pkg::angle_t      x_rotation_angle;
    flight_pkg::angle_t      y_rotation_angle;
    flight_pkg::angle_t      z_rotation_angle;
    flight_pkg::angle_t      x_rotation_rate;
    flight_pkg::angle_t      y_rotation_rate;
    flight_pkg::angle_t      z_rotation_rate;
    logic                    imu_valid;
    logic                    imu_good;
    logic                    motor_1_pwm;
    logic                    motor_2_pwm;
    logic                    motor_3_pwm;
    logic                    motor_4_pwm;
    flight_pkg::motor_rate_t motor_1_rate;
    flight_pkg::motor_rate_t motor_2_rate;
    flight_pkg::motor_rate_t motor_3_rate;
    flight_pkg::motor_rate_t motor_4_rate;
    logic                    motor_valid;

    int cases [MAX_CASES][NUM_COLS];
    int num_cases;
    bit cases_ready;

    flight_ctrl_top #(
        .TICK_DIV(TICK_DIV),
        .PULSE_MIN(PULSE_MIN),
        .FRAME_TICKS(FRAME_TICKS)
    ) dut0 (.*);

    initial begin
        sys_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
        end
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
            abort_run();
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    n;
        int    line_no;
        int    c;
        int    v [NUM_COLS];
        string line;
        byte   ch;
        line_no = 0;
        fd = $fopen("sim/flight_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the cases file sim/flight_cases.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            ch = line.getc(0);
            // Comment and blank lines
            if (ch == "#" || ch == "\n" || ch == "\r") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                        v[8], v[9], v[10], v[11], v[12], v[13], v[14]);
            if (n != NUM_COLS) begin
                $display("cases file line %0d is malformed, %0d values instead of %0d",
                         line_no, n, NUM_COLS);
                abort_run();
            end
            if (num_cases >= MAX_CASES) begin
                $display("cases file holds more than %0d cases", MAX_CASES);
                abort_run();
            end
            for (c = 0; c < NUM_COLS; c++) begin
                cases[num_cases][c] = v[c];
            end
            num_cases++;
        end
        $fclose(fd);
        // Burst phase replays cases 1 to 3
        if (num_cases < 4) begin
            $display("cases file needs at least four cases, found %0d", num_cases);
            abort_run();
        end
    endtask

    // Sticks, angles and health of one case, with the IMU strobe
    task automatic drive_sample(input int idx);
        throttle_val     = flight_pkg::stick_t'(cases[idx][0]);
        roll_val         = flight_pkg::stick_t'(cases[idx][1]);
        pitch_val        = flight_pkg::stick_t'(cases[idx][2]);
        yaw_val          = flight_pkg::stick_t'(cases[idx][3]);
        x_rotation_angle = flight_pkg::angle_t'(cases[idx][4]);
        y_rotation_angle = flight_pkg::angle_t'(cases[idx][5]);
        z_rotation_angle = flight_pkg::angle_t'(cases[idx][6]);
        imu_good         = (cases[idx][10] != 0);
        imu_valid        = 1'b1;
    endtask

    // Gyro rates, read by the rate stage one cycle after the strobe
    task automatic drive_rates(input int idx);
        x_rotation_rate = flight_pkg::angle_t'(cases[idx][7]);
        y_rotation_rate = flight_pkg::angle_t'(cases[idx][8]);
        z_rotation_rate = flight_pkg::angle_t'(cases[idx][9]);
    endtask

    task automatic check_rates(input int idx);
        check_value($sformatf("case %0d motor_1_rate", idx), int'(motor_1_rate), cases[idx][11]);
        check_value($sformatf("case %0d motor_2_rate", idx), int'(motor_2_rate), cases[idx][12]);
        check_value($sformatf("case %0d motor_3_rate", idx), int'(motor_3_rate), cases[idx][13]);
        check_value($sformatf("case %0d motor_4_rate", idx), int'(motor_4_rate), cases[idx][14]);
    endtask

    // All channels rise together at a frame start
    task automatic wait_frame_start();
        logic prev;
        int   n;
        prev = motor_1_pwm;
        for (n = 0; n <= 2 * FRAME_CYCLES; n++) begin
            @(negedge sys_clk);
            if (motor_1_pwm && !prev) begin
                return;
            end
            prev = motor_1_pwm;
        end
        $display("no PWM frame start seen within two frames");
        abort_run();
    endtask

    task automatic measure_pwm(input int idx);
        int         high [4];
        int         s;
        int         ch;
        logic [3:0] pwm_now;
        // First full frame with the new rates is skipped
        wait_frame_start();
        wait_frame_start();
        high = '{0, 0, 0, 0};
        for (s = 0; s < FRAME_CYCLES; s++) begin
            if (s > 0) begin
                @(negedge sys_clk);
            end
            pwm_now = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
            for (ch = 0; ch < 4; ch++) begin
                if (pwm_now[ch]) begin
                    high[ch]++;
                end
            end
        end
        for (ch = 0; ch < 4; ch++) begin
            check_value($sformatf("case %0d motor_%0d_pwm high cycles", idx, ch + 1),
                        high[ch], (PULSE_MIN + cases[idx][11 + ch]) * TICK_DIV);
        end
    endtask

    task automatic run_single_case(input int idx);
        int waited;
        @(negedge sys_clk);
        drive_sample(idx);
        drive_rates(idx);
        @(negedge sys_clk);
        imu_valid = 1'b0;
        waited = 1;
        while (!motor_valid) begin
            if (waited >= VALID_WAIT) begin
                $display("motor_valid never arrived for case %0d", idx);
                abort_run();
            end
            @(negedge sys_clk);
            waited++;
        end
        check_value($sformatf("case %0d strobe latency", idx), waited, LATENCY);
        check_rates(idx);
        // Strobe lasts one cycle only
        @(negedge sys_clk);
        check_value($sformatf("case %0d motor_valid after pulse", idx), int'(motor_valid), 0);
        measure_pwm(idx);
    endtask

    // Three strobes on consecutive cycles, three pulses back out
    task automatic run_burst(input int first);
        int k;
        for (k = 0; k < 8; k++) begin
            @(negedge sys_clk);
            if (k >= LATENCY && k < LATENCY + 3) begin
                check_value($sformatf("burst slot %0d motor_valid", k), int'(motor_valid), 1);
                check_rates(first + k - LATENCY);
            end else begin
                check_value($sformatf("burst slot %0d motor_valid", k), int'(motor_valid), 0);
            end
            if (k < 3) begin
                drive_sample(first + k);
                drive_rates(k == 0 ? first : first + k - 1);
            end else if (k == 3) begin
                imu_valid = 1'b0;
                drive_rates(first + 2);
            end
        end
    endtask

    initial begin
        int limit_ns;
        wait (cases_ready);
        limit_ns = num_cases * (FRAME_CYCLES * 3 + 10) * CLK_PERIOD;
        #(limit_ns);
        $display("timeout, the run did not finish within %0d ns", limit_ns);
        abort_run();
    end

    initial begin
        int i;
        num_cases        = 0;
        cases_ready      = 1'b0;
        resetn           = 1'b0;
        throttle_val     = '0;
        roll_val         = '0;
        pitch_val        = '0;
        yaw_val          = '0;
        x_rotation_angle = '0;
        y_rotation_angle = '0;
        z_rotation_angle = '0;
        x_rotation_rate  = '0;
        y_rotation_rate  = '0;
        z_rotation_rate  = '0;
        imu_valid        = 1'b0;
        imu_good         = 1'b0;
        load_cases();
        cases_ready = 1'b1;
        repeat (3) @(negedge sys_clk);
        resetn = 1'b1;
        for (i = 0; i < num_cases; i++) begin
            run_single_case(i);
        end
        run_burst(1);
        $display("Test passed");
        $finish;
    end

endmodule

// ==== source/angle_controller.sv ====
// Angle controller turning stick inputs into roll and pitch angle errors and a yaw rate target
`timescale 1ns/1ps

module angle_controller #(
    parameter int ANGLE_SHIFT = flight_pkg::ANGLE_SHIFT
) (
    input  logic               sys_clk,
    input  logic               resetn,
    input  flight_pkg::stick_t throttle_val,
    input  flight_pkg::stick_t roll_val,
    input  flight_pkg::stick_t pitch_val,
    input  flight_pkg::stick_t yaw_val,
    input  flight_pkg::angle_t x_rotation_angle,
    input  flight_pkg::angle_t y_rotation_angle,
    input  logic               imu_valid,
    input  logic               imu_good,
    axis_if.source             axis_out
);

    // Centered stick offsets, -128 to 127
    flight_pkg::wide_t roll_off;
    flight_pkg::wide_t pitch_off;
    flight_pkg::wide_t yaw_off;
    // Unsaturated errors and yaw target
    flight_pkg::wide_t roll_err;
    flight_pkg::wide_t pitch_err;
    flight_pkg::wide_t yaw_tgt;
    logic              arm_now;

    always_comb begin
        roll_off  = flight_pkg::wide_t'(roll_val) - flight_pkg::STICK_CENTER;
        pitch_off = flight_pkg::wide_t'(pitch_val) - flight_pkg::STICK_CENTER;
        yaw_off   = flight_pkg::wide_t'(yaw_val) - flight_pkg::STICK_CENTER;
        // Roll is measured about y, pitch about x
        roll_err  = (roll_off <<< ANGLE_SHIFT) - flight_pkg::wide_t'(y_rotation_angle);
        pitch_err = (pitch_off <<< ANGLE_SHIFT) - flight_pkg::wide_t'(x_rotation_angle);
        // Yaw has no angle hold, stick commands a rate
        yaw_tgt   = yaw_off <<< ANGLE_SHIFT;
    end

    // Arm only with a healthy IMU and throttle above idle
    assign arm_now = imu_good &&
                     (throttle_val >= flight_pkg::stick_t'(flight_pkg::THROTTLE_IDLE));

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            axis_out.valid <= 1'b0;
            axis_out.armed <= 1'b0;
        end else begin
            axis_out.valid <= imu_valid;
            if (imu_valid) begin
                axis_out.armed <= arm_now;
            end
        end
    end

    // Sample latch, held until the next IMU strobe
    always_ff @(posedge sys_clk) begin
        if (imu_valid) begin
            axis_out.roll     <= flight_pkg::sat_angle(roll_err);
            axis_out.pitch    <= flight_pkg::sat_angle(pitch_err);
            axis_out.yaw      <= flight_pkg::sat_angle(yaw_tgt);
            axis_out.throttle <= throttle_val;
        end
    end

endmodule

// ==== source/axis_if.sv ====
// Axis stage link carrying roll, pitch and yaw values with throttle, armed flag and valid strobe
`timescale 1ns/1ps

interface axis_if;
    flight_pkg::angle_t roll;
    flight_pkg::angle_t pitch;
    flight_pkg::angle_t yaw;
    flight_pkg::stick_t throttle;
    // Motors allowed to spin
    logic               armed;
    // One cycle strobe, fields hold until the next one
    logic               valid;

    modport source (output roll, pitch, yaw, throttle, armed, valid);
    modport sink   (input  roll, pitch, yaw, throttle, armed, valid);
endinterface

// ==== source/flight_ctrl_top.sv ====
// Attitude path top level chaining angle, rate, mixer and PWM stages behind plain ports
`timescale 1ns/1ps

module flight_ctrl_top #(
    parameter int ANGLE_SHIFT = flight_pkg::ANGLE_SHIFT,
    parameter int ERR_SHIFT   = flight_pkg::ERR_SHIFT,
    parameter int KP_SHIFT    = flight_pkg::KP_SHIFT,
    // 4 us tick from a 38 MHz clock
    parameter int TICK_DIV    = 152,
    parameter int PULSE_MIN   = 250,
    parameter int FRAME_TICKS = 625
) (
    input  logic                    sys_clk,
    input  logic                    resetn,
    input  flight_pkg::stick_t      throttle_val,
    input  flight_pkg::stick_t      roll_val,
    input  flight_pkg::stick_t      pitch_val,
    input  flight_pkg::stick_t      yaw_val,
    input  flight_pkg::angle_t      x_rotation_angle,
    input  flight_pkg::angle_t      y_rotation_angle,
    input  flight_pkg::angle_t      z_rotation_angle,
    input  flight_pkg::angle_t      x_rotation_rate,
    input  flight_pkg::angle_t      y_rotation_rate,
    input  flight_pkg::angle_t      z_rotation_rate,
    input  logic                    imu_valid,
    input  logic                    imu_good,
    output logic                    motor_1_pwm,
    output logic                    motor_2_pwm,
    output logic                    motor_3_pwm,
    output logic                    motor_4_pwm,
    output flight_pkg::motor_rate_t motor_1_rate,
    output flight_pkg::motor_rate_t motor_2_rate,
    output flight_pkg::motor_rate_t motor_3_rate,
    output flight_pkg::motor_rate_t motor_4_rate,
    output logic                    motor_valid
);

    // Stage links
    axis_if  err_axis ();
    axis_if  cmd_axis ();
    motor_if mix_motor ();

    angle_controller #(.ANGLE_SHIFT(ANGLE_SHIFT)) u_angle (
        .sys_clk(sys_clk),
        .resetn(resetn),
        .throttle_val(throttle_val),
        .roll_val(roll_val),
        .pitch_val(pitch_val),
        .yaw_val(yaw_val),
        .x_rotation_angle(x_rotation_angle),
        .y_rotation_angle(y_rotation_angle),
        .imu_valid(imu_valid),
        .imu_good(imu_good),
        .axis_out(err_axis.source)
    );

    rate_controller #(.ERR_SHIFT(ERR_SHIFT), .KP_SHIFT(KP_SHIFT)) u_rate (
        .sys_clk(sys_clk),
        .resetn(resetn),
        .x_rotation_rate(x_rotation_rate),
        .y_rotation_rate(y_rotation_rate),
        .z_rotation_rate(z_rotation_rate),
        .axis_in(err_axis.sink),
        .axis_out(cmd_axis.source)
    );

    motor_mixer u_mixer (
        .sys_clk(sys_clk),
        .resetn(resetn),
        .axis_in(cmd_axis.sink),
        .motor_out(mix_motor.source)
    );

    pwm_generator #(
        .TICK_DIV(TICK_DIV),
        .PULSE_MIN(PULSE_MIN),
        .FRAME_TICKS(FRAME_TICKS)
    ) u_pwm (
        .sys_clk(sys_clk),
        .resetn(resetn),
        .motor_in(mix_motor.sink),
        .motor_1_pwm(motor_1_pwm),
        .motor_2_pwm(motor_2_pwm),
        .motor_3_pwm(motor_3_pwm),
        .motor_4_pwm(motor_4_pwm)
    );

    // Telemetry taps on the mixer output
    assign motor_1_rate = mix_motor.rate_1;
    assign motor_2_rate = mix_motor.rate_2;
    assign motor_3_rate = mix_motor.rate_3;
    assign motor_4_rate = mix_motor.rate_4;
    assign motor_valid  = mix_motor.valid;

endmodule

// ==== source/flight_pkg.sv ====
// Flight control package holding the value widths, types, gains and saturation helpers
package flight_pkg;

    // Value widths
    localparam int STICK_W = 8;
    localparam int ANGLE_W = 16;
    localparam int MOTOR_W = 8;
    localparam int WIDE_W  = 32;

    typedef logic [STICK_W-1:0]        stick_t;
    typedef logic signed [ANGLE_W-1:0] angle_t;
    typedef logic [MOTOR_W-1:0]        motor_rate_t;
    // Intermediate type, wide enough for shifted offsets and sums
    typedef logic signed [WIDE_W-1:0]  wide_t;

    // Stick neutral point
    localparam int STICK_CENTER  = 128;
    // Default gains as shift amounts
    localparam int ANGLE_SHIFT   = 4;
    localparam int ERR_SHIFT     = 2;
    localparam int KP_SHIFT      = 4;
    // Axis command and motor limits
    localparam int AXIS_CMD_MAX  = 64;
    localparam int MOTOR_MAX     = 250;
    localparam int THROTTLE_IDLE = 16;

    localparam wide_t ANGLE_HI = (wide_t'(1) <<< (ANGLE_W - 1)) - 1;
    localparam wide_t ANGLE_LO = -(wide_t'(1) <<< (ANGLE_W - 1));

    // Clip a wide value into the angle_t range
    function automatic angle_t sat_angle(input wide_t v);
        if (v > ANGLE_HI) return angle_t'(ANGLE_HI);
        if (v < ANGLE_LO) return angle_t'(ANGLE_LO);
        return angle_t'(v);
    endfunction

    // Clip a wide value to +/- AXIS_CMD_MAX
    function automatic angle_t sat_cmd(input wide_t v);
        if (v > wide_t'(AXIS_CMD_MAX)) return angle_t'(AXIS_CMD_MAX);
        if (v < -wide_t'(AXIS_CMD_MAX)) return angle_t'(-AXIS_CMD_MAX);
        return angle_t'(v);
    endfunction

endpackage

// ==== source/motor_if.sv ====
// Motor rate link carrying four motor rates and their valid strobe from mixer to PWM
`timescale 1ns/1ps

interface motor_if;
    flight_pkg::motor_rate_t rate_1;
    flight_pkg::motor_rate_t rate_2;
    flight_pkg::motor_rate_t rate_3;
    flight_pkg::motor_rate_t rate_4;
    // One cycle strobe with each new rate set
    logic                    valid;

    modport source (output rate_1, rate_2, rate_3, rate_4, valid);
    modport sink   (input  rate_1, rate_2, rate_3, rate_4, valid);
endinterface

// ==== source/motor_mixer.sv ====
// X-frame motor mixer producing four clamped motor rates with disarm gating
`timescale 1ns/1ps

module motor_mixer (
    input  logic    sys_clk,
    input  logic    resetn,
    axis_if.sink    axis_in,
    motor_if.source motor_out
);

    flight_pkg::wide_t thr;
    flight_pkg::wide_t pit;
    flight_pkg::wide_t rol;
    flight_pkg::wide_t yaw;
    flight_pkg::wide_t sum_1;
    flight_pkg::wide_t sum_2;
    flight_pkg::wide_t sum_3;
    flight_pkg::wide_t sum_4;

    // Limit a motor sum to 0..MOTOR_MAX
    function automatic flight_pkg::motor_rate_t clamp_motor(input flight_pkg::wide_t v);
        if (v < 0) return '0;
        if (v > flight_pkg::wide_t'(flight_pkg::MOTOR_MAX)) begin
            return flight_pkg::motor_rate_t'(flight_pkg::MOTOR_MAX);
        end
        return flight_pkg::motor_rate_t'(v);
    endfunction

    always_comb begin
        thr   = flight_pkg::wide_t'(axis_in.throttle);
        pit   = flight_pkg::wide_t'(axis_in.pitch);
        rol   = flight_pkg::wide_t'(axis_in.roll);
        yaw   = flight_pkg::wide_t'(axis_in.yaw);
        // Front pair on +pitch, diagonals share yaw sign
        sum_1 = thr + pit + rol - yaw;
        sum_2 = thr + pit - rol + yaw;
        sum_3 = thr - pit - rol - yaw;
        sum_4 = thr - pit + rol + yaw;
    end

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            motor_out.valid  <= 1'b0;
            motor_out.rate_1 <= '0;
            motor_out.rate_2 <= '0;
            motor_out.rate_3 <= '0;
            motor_out.rate_4 <= '0;
        end else begin
            motor_out.valid <= axis_in.valid;
            if (axis_in.valid) begin
                // Disarmed means all motors stopped
                motor_out.rate_1 <= axis_in.armed ? clamp_motor(sum_1) : '0;
                motor_out.rate_2 <= axis_in.armed ? clamp_motor(sum_2) : '0;
                motor_out.rate_3 <= axis_in.armed ? clamp_motor(sum_3) : '0;
                motor_out.rate_4 <= axis_in.armed ? clamp_motor(sum_4) : '0;
            end
        end
    end

endmodule

// ==== source/pwm_generator.sv ====
// ESC PWM generator with a shared frame counter and four pulse width comparators
`timescale 1ns/1ps

module pwm_generator #(
    parameter int TICK_DIV    = 152,
    parameter int PULSE_MIN   = 250,
    // Must exceed PULSE_MIN + MOTOR_MAX so every pulse ends inside its frame
    parameter int FRAME_TICKS = 625
) (
    input  logic  sys_clk,
    input  logic  resetn,
    motor_if.sink motor_in,
    output logic  motor_1_pwm,
    output logic  motor_2_pwm,
    output logic  motor_3_pwm,
    output logic  motor_4_pwm
);

    localparam int TW = $clog2(TICK_DIV + 1);
    localparam int FW = $clog2(FRAME_TICKS + 1);

    logic [TW-1:0]           tick_cnt;
    logic [FW-1:0]           frame_cnt;
    logic [FW-1:0]           frame_next;
    logic                    tick;
    logic                    frame_wrap;
    flight_pkg::motor_rate_t rate_in [4];
    flight_pkg::motor_rate_t rate_q [4];
    flight_pkg::motor_rate_t rate_next [4];
    logic                    pwm_q [4];

    assign rate_in[0] = motor_in.rate_1;
    assign rate_in[1] = motor_in.rate_2;
    assign rate_in[2] = motor_in.rate_3;
    assign rate_in[3] = motor_in.rate_4;

    // One tick every TICK_DIV clocks
    assign tick       = (tick_cnt == TW'(TICK_DIV - 1));
    // Last tick of the frame
    assign frame_wrap = tick && (frame_cnt == FW'(FRAME_TICKS - 1));

    always_comb begin
        if (frame_wrap) begin
            frame_next = '0;
        end else if (tick) begin
            frame_next = frame_cnt + 1'b1;
        end else begin
            frame_next = frame_cnt;
        end
    end

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            tick_cnt  <= '0;
            frame_cnt <= '0;
        end else begin
            tick_cnt  <= tick ? '0 : tick_cnt + 1'b1;
            frame_cnt <= frame_next;
        end
    end

    for (genvar ch = 0; ch < 4; ch++) begin : g_chan
        // New rate takes effect only at a frame start
        assign rate_next[ch] = frame_wrap ? rate_in[ch] : rate_q[ch];

        // Output compares against the counter value it sits beside
        always_ff @(posedge sys_clk or negedge resetn) begin
            if (!resetn) begin
                rate_q[ch] <= '0;
                pwm_q[ch]  <= 1'b0;
            end else begin
                rate_q[ch] <= rate_next[ch];
                pwm_q[ch]  <= int'(frame_next) < (PULSE_MIN + int'(rate_next[ch]));
            end
        end
    end

    assign motor_1_pwm = pwm_q[0];
    assign motor_2_pwm = pwm_q[1];
    assign motor_3_pwm = pwm_q[2];
    assign motor_4_pwm = pwm_q[3];

endmodule

// ==== source/rate_controller.sv ====
// Rate controller applying a proportional, saturated correction against the gyro rates per axis
`timescale 1ns/1ps

module rate_controller #(
    parameter int ERR_SHIFT = flight_pkg::ERR_SHIFT,
    parameter int KP_SHIFT  = flight_pkg::KP_SHIFT
) (
    input  logic               sys_clk,
    input  logic               resetn,
    input  flight_pkg::angle_t x_rotation_rate,
    input  flight_pkg::angle_t y_rotation_rate,
    input  flight_pkg::angle_t z_rotation_rate,
    axis_if.sink               axis_in,
    axis_if.source             axis_out
);

    // Rate targets
    flight_pkg::wide_t roll_tgt;
    flight_pkg::wide_t pitch_tgt;
    flight_pkg::wide_t yaw_tgt;
    // Unsaturated commands
    flight_pkg::wide_t roll_cmd;
    flight_pkg::wide_t pitch_cmd;
    flight_pkg::wide_t yaw_cmd;

    always_comb begin
        // Angle error scaled down to a rate target
        roll_tgt  = flight_pkg::wide_t'(axis_in.roll) >>> ERR_SHIFT;
        pitch_tgt = flight_pkg::wide_t'(axis_in.pitch) >>> ERR_SHIFT;
        // Yaw already arrives as a rate
        yaw_tgt   = flight_pkg::wide_t'(axis_in.yaw);
        // Gyro pairing is roll/x, pitch/y, yaw/z
        roll_cmd  = (roll_tgt - flight_pkg::wide_t'(x_rotation_rate)) >>> KP_SHIFT;
        pitch_cmd = (pitch_tgt - flight_pkg::wide_t'(y_rotation_rate)) >>> KP_SHIFT;
        yaw_cmd   = (yaw_tgt - flight_pkg::wide_t'(z_rotation_rate)) >>> KP_SHIFT;
    end

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            axis_out.valid <= 1'b0;
            axis_out.armed <= 1'b0;
        end else begin
            axis_out.valid <= axis_in.valid;
            if (axis_in.valid) begin
                axis_out.armed <= axis_in.armed;
            end
        end
    end

    // Gyro rates are taken in the cycle the angle stage strobes
    always_ff @(posedge sys_clk) begin
        if (axis_in.valid) begin
            axis_out.roll     <= flight_pkg::sat_cmd(roll_cmd);
            axis_out.pitch    <= flight_pkg::sat_cmd(pitch_cmd);
            axis_out.yaw      <= flight_pkg::sat_cmd(yaw_cmd);
            axis_out.throttle <= axis_in.throttle;
        end
    end

endmodule

// ==== src.f ====
source/flight_pkg.sv
source/axis_if.sv
source/motor_if.sv
source/angle_controller.sv
source/rate_controller.sv
source/motor_mixer.sv
source/pwm_generator.sv
source/flight_ctrl_top.sv
sim/flight_ctrl_assertions.sv
sim/flight_ctrl_tb.sv
